//--- common/mipsPkg.sv
`default_nettype none

package mipsPkg;

	// Basic widths
	typedef logic [31:0] word_t;
	typedef logic [4:0] regAddr_t;
	typedef logic [31:0] instr_t;

	localparam int numRegs = 32;

	////////////////////////////////////////
	// Instruction fields
	localparam int opMsb = 31;
	localparam int opLsb = 26;
	localparam int rsMsb = 25;
	localparam int rsLsb = 21;
	localparam int rtMsb = 20;
	localparam int rtLsb = 16;
	localparam int rdMsb = 15;
	localparam int rdLsb = 11;
	localparam int fnMsb = 5;
	localparam int fnLsb = 0;
	localparam int immMsb = 15;
	localparam int immLsb = 0;

	// Opcodes
	localparam logic [5:0] opRType = 6'h00;
	localparam logic [5:0] opAddi = 6'h08;
	localparam logic [5:0] opOri = 6'h0D;
	localparam logic [5:0] opLui = 6'h0F;

	// R-type funct codes
	localparam logic [5:0] fnAdd = 6'h20;
	localparam logic [5:0] fnSub = 6'h22;
	localparam logic [5:0] fnAnd = 6'h24;
	localparam logic [5:0] fnOr = 6'h25;
	localparam logic [5:0] fnSlt = 6'h2A;

	////////////////////////////////////////
	// Decoded controls
	typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluSlt, aluLui} aluOp_t;
	typedef enum logic [1:0] {immNone, immSign, immZero} immKind_t;

	// Execute stage, forward flags pick wbStage result
	typedef struct packed {
		logic valid;
		aluOp_t aluOp;
		immKind_t immKind;
		logic [15:0] imm16;
		regAddr_t dest;
		logic forwardA;
		logic forwardB;
	} exStage_t;

	// Writeback stage
	typedef struct packed {
		logic valid;
		regAddr_t dest;
		word_t result;
	} wbStage_t;

endpackage

`default_nettype wire

//--- registerFile/registerFile.sv
`timescale 1ns/1ns
`default_nettype none

module registerFile
	import mipsPkg::*;
(
	input wire clk,
	input wire reset,
	// Read addresses
	input wire regAddr_t rs,
	input wire regAddr_t rt,
	// Write port
	input wire writeEnable,
	input wire regAddr_t writeAddr,
	input wire word_t writeData,
	// Registered read data
	output word_t rd1,
	output word_t rd2
);

	// Storage array
	word_t regs [numRegs];

	////////////////////////////////////////
	// Read path

	// One read port
	// r0 forced to zero
	// Same-edge write passes straight through
	function automatic word_t readPort(input regAddr_t addr);
		word_t value;
		if (addr == '0)
			value = '0;
		else if (writeEnable && (writeAddr == addr))
			value = writeData;
		else
			value = regs[addr];
		return value;
	endfunction

	////////////////////////////////////////
	// Storage and read registers

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			// Clear whole file
			for (int i = 0; i < numRegs; i++)
				regs[i] <= '0;
			rd1 <= '0;
			rd2 <= '0;
		end
		else
		begin
			// Writes to r0 dropped
			if (writeEnable && (writeAddr != '0))
				regs[writeAddr] <= writeData;

			// Reads update every edge
			rd1 <= readPort(rs);
			rd2 <= readPort(rt);
		end
	end

	// Both ports behave the same
	// readPort keeps them in step
	// Data lands one cycle after address

endmodule

`default_nettype wire

//--- verilog/decodeControl.sv
`timescale 1ns/1ns
`default_nettype none

module decodeControl
	import mipsPkg::*;
(
	input wire clk,
	input wire reset,
	input wire instrValid,
	input wire instr_t instr,
	// Result of the execute stage
	input wire word_t aluResult,
	// Source addresses to register file
	output regAddr_t rs,
	output regAddr_t rt,
	// Pipeline registers
	output exStage_t exStage,
	output wbStage_t wbStage
);

	// Raw fields
	logic [5:0] opcode;
	logic [5:0] funct;

	// Decode results
	aluOp_t decAluOp;
	immKind_t decImmKind;
	regAddr_t decDest;

	// Forward requests
	logic fwdA;
	logic fwdB;

	////////////////////////////////////////
	// Field split
	assign opcode = instr[opMsb:opLsb];
	assign funct = instr[fnMsb:fnLsb];
	assign rs = instr[rsMsb:rsLsb];
	assign rt = instr[rtMsb:rtLsb];

	////////////////////////////////////////
	// Opcode and funct decode
	always_comb
	begin
		// Default is a no-op writing nothing
		decAluOp = aluAdd;
		decImmKind = immNone;
		decDest = '0;
		case (opcode)
			opRType:
			begin
				// R-type writes rd
				decDest = instr[rdMsb:rdLsb];
				case (funct)
					fnAdd: decAluOp = aluAdd;
					fnSub: decAluOp = aluSub;
					fnAnd: decAluOp = aluAnd;
					fnOr: decAluOp = aluOr;
					fnSlt: decAluOp = aluSlt;
					default: decDest = '0;
				endcase
			end
			opAddi:
			begin
				decImmKind = immSign;
				decDest = rt;
			end
			opOri:
			begin
				decAluOp = aluOr;
				decImmKind = immZero;
				decDest = rt;
			end
			opLui:
			begin
				// Upper half taken from B
				decAluOp = aluLui;
				decImmKind = immZero;
				decDest = rt;
			end
			default: decDest = '0;
		endcase
	end

	////////////////////////////////////////
	// Forwarding against in-flight instruction
	// Only a valid stage with nonzero dest counts
	assign fwdA = exStage.valid && (exStage.dest != '0) && (exStage.dest == rs);
	assign fwdB = exStage.valid && (exStage.dest != '0) && (exStage.dest == rt);

	// Pipeline registers
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			exStage <= '0;
			wbStage <= '0;
		end
		else
		begin
			exStage <= '{valid: instrValid, aluOp: decAluOp, immKind: decImmKind,
				imm16: instr[immMsb:immLsb], dest: decDest,
				forwardA: fwdA, forwardB: fwdB};
			// Result captured one edge later
			wbStage <= '{valid: exStage.valid, dest: exStage.dest, result: aluResult};
		end
	end

endmodule

`default_nettype wire

//--- verilog/aluUnit.sv
`timescale 1ns/1ns
`default_nettype none

module aluUnit
	import mipsPkg::*;
(
	input wire exStage_t exStage,
	// Register file data
	input wire word_t rd1,
	input wire word_t rd2,
	// Writeback stage for forwarding
	input wire wbStage_t wbStage,
	output word_t aluResult
);

	word_t opA;
	word_t regB;
	word_t immExt;
	word_t opB;

	////////////////////////////////////////
	// Operand select

	// Forward newest result when flagged
	assign opA = exStage.forwardA ? wbStage.result : rd1;
	assign regB = exStage.forwardB ? wbStage.result : rd2;

	// Immediate extension
	always_comb
	begin
		case (exStage.immKind)
			immSign: immExt = {{16{exStage.imm16[15]}}, exStage.imm16};
			immZero: immExt = {16'h0000, exStage.imm16};
			default: immExt = '0;
		endcase
	end

	// Immediate replaces register B
	assign opB = (exStage.immKind == immNone) ? regB : immExt;

	////////////////////////////////////////
	// Operations
	always_comb
	begin
		case (exStage.aluOp)
			aluAdd: aluResult = opA + opB;
			aluSub: aluResult = opA - opB;
			aluAnd: aluResult = opA & opB;
			aluOr: aluResult = opA | opB;
			// Signed compare
			aluSlt: aluResult = ($signed(opA) < $signed(opB)) ? 32'd1 : 32'd0;
			// Immediate into upper half
			aluLui: aluResult = {opB[15:0], 16'h0000};
			default: aluResult = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/executeCore.sv
`timescale 1ns/1ns
`default_nettype none

module executeCore
	import mipsPkg::*;
(
	input wire clk,
	input wire reset,
	input wire instrValid,
	input wire instr_t instr,
	// Writeback view
	output logic resultValid,
	output regAddr_t resultDest,
	output word_t result
);

	regAddr_t rs;
	regAddr_t rt;
	word_t rd1;
	word_t rd2;
	word_t aluResult;
	exStage_t exStage;
	wbStage_t wbStage;

	////////////////////////////////////////
	// Control and pipeline registers
	decodeControl decode (.clk(clk), .reset(reset), .instrValid(instrValid),
		.instr(instr), .aluResult(aluResult), .rs(rs), .rt(rt),
		.exStage(exStage), .wbStage(wbStage));

	// Write port fed from writeback stage
	registerFile regFile (.clk(clk), .reset(reset), .rs(rs), .rt(rt),
		.writeEnable(wbStage.valid), .writeAddr(wbStage.dest),
		.writeData(wbStage.result), .rd1(rd1), .rd2(rd2));

	// Execute
	aluUnit alu (.exStage(exStage), .rd1(rd1), .rd2(rd2), .wbStage(wbStage),
		.aluResult(aluResult));

	////////////////////////////////////////
	// Result ports
	assign resultValid = wbStage.valid;
	assign resultDest = wbStage.dest;
	assign result = wbStage.result;

endmodule

`default_nettype wire

//--- dv/executeCore_props.sv
`timescale 1ns/1ns
`default_nettype none

module executeCore_props
	import mipsPkg::*;
(
	input wire clk,
	input wire reset,
	input wire instrValid,
	input wire exStage_t exStage,
	input wire wbStage_t wbStage
);

	// Failure count read by the testbench
	int propFails = 0;

	////////////////////////////////////////
	// Stage valid pipeline
	exValidFollows: assert property (@(posedge clk)
		!reset |=> (exStage.valid == $past(instrValid)))
	else
	begin
		propFails++;
		$error("exStage valid did not follow instrValid");
	end

	wbValidFollows: assert property (@(posedge clk)
		!reset |=> (wbStage.valid == $past(exStage.valid)))
	else
	begin
		propFails++;
		$error("wbStage valid did not follow exStage valid");
	end

	// Forward only from a valid, nonzero dest
	noForwardFromZero: assert property (@(posedge clk) disable iff (reset)
		(exStage.forwardA || exStage.forwardB) |->
			($past(exStage.valid) && ($past(exStage.dest) != '0)))
	else
	begin
		propFails++;
		$error("Forward flag set without a valid nonzero dest in flight");
	end

	// Both stages empty after reset
	validLowAfterReset: assert property (@(posedge clk)
		reset |=> (!exStage.valid && !wbStage.valid))
	else
	begin
		propFails++;
		$error("Stage valid bit high in the cycle after reset");
	end

endmodule

`default_nettype wire

//--- dv/executeCore_tb.sv
`timescale 1ns/1ns
`default_nettype none

module executeCore_tb;
	import mipsPkg::*;

	localparam int traceLines = 34;
	localparam int traceCols = 5;
	localparam int clkPeriod = 100;

	logic clk;
	logic reset;
	logic instrValid;
	instr_t instr;
	logic resultValid;
	regAddr_t resultDest;
	word_t result;

	// Trace columns: strobe, instr, expValid, expDest, expResult
	logic [31:0] traceMem [0:traceLines*traceCols-1];

	// Error counters
	int validErrors;
	int destErrors;
	int resultErrors;
	int loadErrors;
	int propErrors;

	executeCore uut (.clk(clk), .reset(reset), .instrValid(instrValid), .instr(instr),
		.resultValid(resultValid), .resultDest(resultDest), .result(result));

	// Pipeline control properties
	bind decodeControl executeCore_props props (.clk(clk), .reset(reset),
		.instrValid(instrValid), .exStage(exStage), .wbStage(wbStage));

	////////////////////////////////////////
	// Clock
	initial clk = 1'b0;
	always #(clkPeriod / 2) clk = ~clk;

	// Strobe and instruction for one trace line
	task automatic driveLine(input int line);
		instrValid = traceMem[line*traceCols][0];
		instr = traceMem[line*traceCols+1];
	endtask

	// Writeback view against one trace line
	task automatic checkLine(input int line);
		logic expValid;
		regAddr_t expDest;
		word_t expResult;
		expValid = traceMem[line*traceCols+2][0];
		expDest = traceMem[line*traceCols+3][4:0];
		expResult = traceMem[line*traceCols+4];
		assert (resultValid === expValid)
		else
		begin
			validErrors++;
			$display("** Error at %0t ns: line %0d resultValid %b, expected %b",
				$time, line, resultValid, expValid);
		end
		// Dest and data only matter on a valid result
		if (expValid)
		begin
			assert (resultDest === expDest)
			else
			begin
				destErrors++;
				$display("** Error at %0t ns: line %0d resultDest %0d, expected %0d",
					$time, line, resultDest, expDest);
			end
			assert (result === expResult)
			else
			begin
				resultErrors++;
				$display("** Error at %0t ns: line %0d result %h, expected %h",
					$time, line, result, expResult);
			end
		end
	endtask

	////////////////////////////////////////
	// Stimulus and checks
	initial
	begin
		validErrors = 0;
		destErrors = 0;
		resultErrors = 0;
		loadErrors = 0;
		propErrors = 0;
		reset = 1'b1;
		instrValid = 1'b0;
		instr = '0;
		$readmemh("dv/executeCore_trace.txt", traceMem);
		// Last entry unknown means a short or missing file
		if ($isunknown(traceMem[traceLines*traceCols-1]))
		begin
			loadErrors++;
			$display("Trace file is missing or shorter than expected");
		end
		repeat (5) @(posedge clk);
		#5 reset = 1'b0;
		// Check just before each drive
		for (int i = 0; i < traceLines; i++)
		begin
			@(posedge clk);
			#4;
			checkLine(i);
			#1;
			driveLine(i);
		end
		propErrors = uut.decode.props.propFails;
		$display("Errors: valid=%0d dest=%0d result=%0d load=%0d assertions=%0d",
			validErrors, destErrors, resultErrors, loadErrors, propErrors);
		if (validErrors + destErrors + resultErrors + loadErrors + propErrors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

	// Watchdog sized from trace length
	initial
	begin
		#((traceLines + 20) * clkPeriod);
		$display("Watchdog expired before the trace was finished");
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- dv/executeCore_trace.txt
// Columns (hex): strobe instr expValid expDest expResult
// Expected columns show the result of the instruction two lines up
1 20010005 0 00 00000000 // addi r1, r0, 5
1 2002FFFD 0 00 00000000 // addi r2, r0, -3
1 00221820 1 01 00000005 // add r3, r1, r2
1 00222022 1 02 FFFFFFFD // sub r4, r1, r2
1 3406F0F0 1 03 00000002 // ori r6, r0, 0xF0F0
1 34278000 1 04 00000008 // ori r7, r1, 0x8000
1 00C72824 1 06 0000F0F0 // and r5, r6, r7
1 00C74025 1 07 00008005 // or r8, r6, r7
1 3C098000 1 05 00008000 // lui r9, 0x8000
1 0041502A 1 08 0000F0F5 // slt r10, r2, r1
1 0049582A 1 09 80000000 // slt r11, r2, r9
1 0122602A 1 0A 00000001 // slt r12, r9, r2
0 00000000 1 0B 00000000 // idle
1 20000007 1 0C 00000001 // addi r0, r0, 7
1 00016820 0 00 00000000 // add r13, r0, r1
0 00000000 1 00 00000007 // idle
0 00000000 1 0D 00000005 // idle
1 8C0100FF 0 00 00000000 // unknown opcode, rt r1
1 0022703F 0 00 00000000 // unknown funct, rd r14
1 00207820 1 00 00000005 // add r15, r1, r0
1 01C08020 1 00 00000002 // add r16, r14, r0
1 20110100 1 0F 00000005 // addi r17, r0, 0x100
1 22310001 1 10 00000000 // addi r17, r17, 1
1 02209020 1 11 00000100 // add r18, r17, r0
1 00119820 1 11 00000101 // add r19, r0, r17
1 0231A020 1 12 00000101 // add r20, r17, r17
1 0041A822 1 13 00000101 // sub r21, r2, r1
1 3C161234 1 14 00000202 // lui r22, 0x1234
1 36D65678 1 15 FFFFFFF8 // ori r22, r22, 0x5678
1 22D7FF88 1 16 12340000 // addi r23, r22, -0x78
0 00000000 1 16 12345678 // idle
0 00000000 1 17 12345600 // idle
0 00000000 0 00 00000000 // idle
0 00000000 0 00 00000000 // idle

//--- project.f
common/mipsPkg.sv
registerFile/registerFile.sv
verilog/decodeControl.sv
verilog/aluUnit.sv
verilog/executeCore.sv
dv/executeCore_props.sv
dv/executeCore_tb.sv
